// ==== noc_router.f ====
+incdir+src
src/noc_pkg.sv
src/route_compute_xy.sv
src/flit_fifo.sv
src/output_port_alloc.sv
src/noc_router.sv
verif/tb_clock_gen.sv
verif/noc_router_assert.sv
verif/noc_router_tb.sv

// ==== Makefile ====
TOP = noc_router_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert -f noc_router.f --top-module $(TOP)

run: build
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx '=== PASS ==='

lint:
	verilator --lint-only --timing --assert -f noc_router.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== verif/noc_router_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module noc_router_tb import noc_pkg::*; ();

   // output index in port_vec_t order
   localparam logic [2:0] to_local = 3'd0;
   localparam logic [2:0] to_east  = 3'd1;
   localparam logic [2:0] to_west  = 3'd2;
   localparam logic [2:0] to_south = 3'd3;
   localparam logic [2:0] to_north = 3'd4;

   typedef struct packed {
      logic [2:0] src;
      logic [3:0] tag;
      coord_t     dx;
      coord_t     dy;
      logic [2:0] dst;
   } row_t;

   // every destination seen from node 1,1
   localparam row_t route_table [16] = '{
      {3'd0, 4'h0, 2'd0, 2'd0, to_west},
      {3'd1, 4'h1, 2'd0, 2'd1, to_west},
      {3'd2, 4'h2, 2'd0, 2'd2, to_west},
      {3'd3, 4'h3, 2'd0, 2'd3, to_west},
      {3'd4, 4'h4, 2'd1, 2'd0, to_north},
      {3'd0, 4'h5, 2'd1, 2'd1, to_local},
      {3'd1, 4'h6, 2'd1, 2'd2, to_south},
      {3'd2, 4'h7, 2'd1, 2'd3, to_south},
      {3'd3, 4'h8, 2'd2, 2'd0, to_east},
      {3'd4, 4'h9, 2'd2, 2'd1, to_east},
      {3'd0, 4'ha, 2'd2, 2'd2, to_east},
      {3'd1, 4'hb, 2'd2, 2'd3, to_east},
      {3'd2, 4'hc, 2'd3, 2'd0, to_east},
      {3'd3, 4'hd, 2'd3, 2'd1, to_east},
      {3'd4, 4'he, 2'd3, 2'd2, to_east},
      {3'd0, 4'hf, 2'd3, 2'd3, to_east}
   };

   logic      clk;
   logic      arst_n;
   port_vec_t in_valid;
   flit_t     in_flit [`NOC_PORTS];
   port_vec_t in_full;
   port_vec_t out_valid;
   flit_t     out_flit [`NOC_PORTS];

   // scoreboard of flits and arrival cycles per output
   flit_t got_flit [`NOC_PORTS][$];
   int    got_cyc [`NOC_PORTS][$];
   int    cycle_cnt = 0;
   int    seed;

   tb_clock_gen u_clk_gen (
      .clk    (clk),
      .arst_n (arst_n)
   );

   noc_router #(
      .node_x (2'd1),
      .node_y (2'd1)
   ) DUT (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_flit   (in_flit),
      .in_full   (in_full),
      .out_valid (out_valid),
      .out_flit  (out_flit)
   );

   bind noc_router noc_router_assert u_assert (
      .clk       (clk),
      .arst_n    (arst_n),
      .in_valid  (in_valid),
      .in_full   (in_full),
      .out_valid (out_valid),
      .grant     (grant)
   );

   always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

   // outputs are stable on the falling edge
   always @(negedge clk) begin
      for (int j = 0; j < `NOC_PORTS; j++) begin
         if (arst_n && out_valid[j]) begin
            got_flit[j].push_back(out_flit[j]);
            got_cyc[j].push_back(cycle_cnt);
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // helpers
   ////////////////////////////////////////////////////////////
   task automatic fail_run(input string why);
      $display("%s", why);
      $display("=== FAIL ===");
      $fatal(1, "simulation stopped on error");
   endtask

   task automatic check(input int got, input int exp, input string msg);
      if (got != exp) begin
         fail_run($sformatf("MISMATCH at %0d ns: %s, got %0h expected %0h",
                            $time, msg, got, exp));
      end
   endtask

   task automatic strobe(input int i, input flit_t f);
      in_valid[i] = 1'b1;
      in_flit[i]  = f;
   endtask

   // strobes last one cycle
   task automatic next_cycle();
      @(negedge clk);
      in_valid = '0;
   endtask

   task automatic wait_flits(input int j, input int n);
      int waited = 0;
      while (got_flit[j].size() < n) begin
         next_cycle();
         waited++;
         if (waited > 100) begin
            fail_run($sformatf("timeout: output %0d gave %0d of %0d flits",
                               j, got_flit[j].size(), n));
         end
      end
   endtask

   task automatic expect_flit(input int j, input flit_t f, input int cyc);
      wait_flits(j, 1);
      check(int'(got_flit[j].pop_front()), int'(f), $sformatf("flit on output %0d", j));
      check(got_cyc[j].pop_front(), cyc, $sformatf("arrival cycle on output %0d", j));
   endtask

   task automatic check_idle();
      repeat (3) next_cycle();
      for (int j = 0; j < `NOC_PORTS; j++) begin
         check(got_flit[j].size(), 0, $sformatf("stray flits on output %0d", j));
      end
   endtask

   ////////////////////////////////////////////////////////////
   // test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      flit_t     f;
      flit_t     burst [3];
      int        t0;
      int        src;
      int        seq [`NOC_PORTS];
      port_vec_t seen;
      seed     = 16;
      in_valid = '0;
      for (int i = 0; i < `NOC_PORTS; i++) begin
         in_flit[i] = '0;
      end
      t0 = 0;
      while (arst_n !== 1'b1) begin
         next_cycle();
         t0++;
         if (t0 > 10) begin
            fail_run("reset was never released");
         end
      end
      next_cycle();

      // routing and latency for one row at a time
      for (int r = 0; r < 16; r++) begin
         f  = {route_table[r].tag, route_table[r].dx, route_table[r].dy};
         t0 = cycle_cnt;
         strobe(int'(route_table[r].src), f);
         next_cycle();
         expect_flit(int'(route_table[r].dst), f, t0 + 2);
         check_idle();
      end

      // burst of three to east while the others go to distinct outputs
      // low tag bits number the burst so the order shows
      for (int k = 0; k < 3; k++) begin
         burst[k] = {2'($random(seed)), 2'(k), 2'd3, 2'd1};
      end
      t0 = cycle_cnt;
      strobe(1, {4'h1, 2'd0, 2'd1});
      strobe(2, {4'h2, 2'd1, 2'd3});
      strobe(3, {4'h3, 2'd1, 2'd0});
      strobe(4, {4'h4, 2'd1, 2'd1});
      for (int k = 0; k < 3; k++) begin
         strobe(0, burst[k]);
         next_cycle();
      end
      expect_flit(int'(to_west), {4'h1, 2'd0, 2'd1}, t0 + 2);
      expect_flit(int'(to_south), {4'h2, 2'd1, 2'd3}, t0 + 2);
      expect_flit(int'(to_north), {4'h3, 2'd1, 2'd0}, t0 + 2);
      expect_flit(int'(to_local), {4'h4, 2'd1, 2'd1}, t0 + 2);
      for (int k = 0; k < 3; k++) begin
         expect_flit(int'(to_east), burst[k], t0 + 2 + k);
      end
      check_idle();

      // all inputs to east for four cycles
      // tag holds the input and the y bits the sequence number
      t0 = cycle_cnt;
      for (int k = 0; k < 4; k++) begin
         for (int i = 0; i < `NOC_PORTS; i++) begin
            strobe(i, {4'(i), 2'd3, 2'(k)});
         end
         next_cycle();
      end
      check(int'(in_full != '0), 1, "in_full after four queued flits");
      wait_flits(int'(to_east), 20);
      seen = '0;
      seq  = '{default: 0};
      for (int k = 0; k < 20; k++) begin
         f   = got_flit[to_east].pop_front();
         src = int'(f[7:4]);
         check(got_cyc[to_east].pop_front(), t0 + 2 + k, "east not busy every cycle");
         check(int'(src < `NOC_PORTS), 1, "east flit from unknown input");
         check(int'(f[1:0]), seq[src], $sformatf("order of flits from input %0d", src));
         seq[src]++;
         // first round must visit every input once
         if (k < `NOC_PORTS) begin
            check(int'(seen[src]), 0, $sformatf("input %0d granted twice in a round", src));
            seen[src] = 1'b1;
         end
      end
      check(int'(in_full), 0, "in_full after drain");
      check_idle();

      $display("=== PASS ===");
      $finish;
   end

endmodule

`default_nettype wire

// ==== verif/noc_router_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module noc_router_assert import noc_pkg::*; (
   input wire       clk,
   input wire       arst_n,
   input port_vec_t in_valid,
   input port_vec_t in_full,
   input port_vec_t out_valid,
   input port_vec_t grant [`NOC_PORTS]
);

   // sender has to hold off while its fifo is full
   assert property (@(posedge clk) disable iff (!arst_n) (in_valid & in_full) == '0)
      else $error("strobe on a full input, in_valid %b in_full %b", in_valid, in_full);

   // at most one input per output and cycle
   for (genvar j = 0; j < `NOC_PORTS; j++) begin : g_grant
      assert property (@(posedge clk) disable iff (!arst_n) $onehot0(grant[j]))
         else $error("output %0d grants several inputs, grant %b", j, grant[j]);
   end

   // quiet outputs while in reset
   assert property (@(posedge clk) !arst_n |-> (out_valid == '0))
      else $error("out_valid %b during reset", out_valid);

endmodule

`default_nettype wire

// ==== verif/tb_clock_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
   parameter real period_ns    = 4.0,
   parameter int  reset_cycles = 2
) (
   output logic clk,
   output logic arst_n
);

   initial begin
      clk = 1'b0;
      forever begin
         #(period_ns / 2.0);
         clk = ~clk;
      end
   end

   // released on a falling edge, away from the flops
   initial begin
      arst_n = 1'b0;
      repeat (reset_cycles) @(posedge clk);
      @(negedge clk);
      arst_n = 1'b1;
   end

endmodule

`default_nettype wire

// ==== src/noc_router.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module noc_router import noc_pkg::*; #(
   parameter coord_t node_x = 2'd1,
   parameter coord_t node_y = 2'd1
) (
   input  wire       clk,
   input  wire       arst_n,
   input  port_vec_t in_valid,
   input  flit_t     in_flit [`NOC_PORTS],
   output port_vec_t in_full,
   output port_vec_t out_valid,
   output flit_t     out_flit [`NOC_PORTS]
);

   // fifo heads, indexed by input
   flit_t     head [`NOC_PORTS];
   port_vec_t not_empty;

   // route_req[i][j]: input i wants output j
   port_vec_t route_req [`NOC_PORTS];
   // out_req[j][i]: same bits seen from output j
   port_vec_t out_req [`NOC_PORTS];
   // grant[j][i]: output j takes input i
   port_vec_t grant [`NOC_PORTS];
   // one pop per input, merged over all outputs
   port_vec_t pop;

   ////////////////////////////////////////////////////////////
   // input side, fifo plus route per port
   ////////////////////////////////////////////////////////////
   for (genvar i = 0; i < `NOC_PORTS; i++) begin : g_in
      flit_fifo u_fifo (
         .clk       (clk),
         .arst_n    (arst_n),
         .push      (in_valid[i]),
         .push_flit (in_flit[i]),
         .pop       (pop[i]),
         .head      (head[i]),
         .not_empty (not_empty[i]),
         .full      (in_full[i])
      );

      // empty fifo gives no request
      route_compute_xy #(
         .node_x (node_x),
         .node_y (node_y)
      ) u_route (
         .head       (head[i]),
         .head_valid (not_empty[i]),
         .port       (),
         .req        (route_req[i])
      );
   end

   // turn requests around, by output
   for (genvar j = 0; j < `NOC_PORTS; j++) begin : g_req_j
      for (genvar i = 0; i < `NOC_PORTS; i++) begin : g_req_i
         assign out_req[j][i] = route_req[i][j];
      end
   end

   ////////////////////////////////////////////////////////////
   // output side, one arbiter and register per port
   ////////////////////////////////////////////////////////////
   for (genvar j = 0; j < `NOC_PORTS; j++) begin : g_out
      output_port_alloc u_alloc (
         .clk       (clk),
         .arst_n    (arst_n),
         .req       (out_req[j]),
         .flits     (head),
         .grant     (grant[j]),
         .out_valid (out_valid[j]),
         .out_flit  (out_flit[j])
      );
   end

   // requests are one-hot per input, so
   // no input is granted by two outputs
   always_comb begin
      pop = '0;
      for (int j = 0; j < `NOC_PORTS; j++) begin
         pop = pop | grant[j];
      end
   end

endmodule

`default_nettype wire

// ==== src/output_port_alloc.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module output_port_alloc import noc_pkg::*; (
   input  wire       clk,
   input  wire       arst_n,
   input  port_vec_t req,
   input  flit_t     flits [`NOC_PORTS],
   output port_vec_t grant,
   output logic      out_valid,
   output flit_t     out_flit
);

   localparam int IDX_W = $clog2(`NOC_PORTS);

   // input with highest priority this cycle
   logic [IDX_W-1:0] ptr;
   // winning input
   logic [IDX_W-1:0] sel;
   logic [IDX_W-1:0] ptr_next;
   logic             any_req;

   assign any_req = |req;

   ////////////////////////////////////////////////////////////
   // round robin, scan from ptr upward and wrap at 5
   ////////////////////////////////////////////////////////////
   always_comb begin
      int   idx;
      logic found;
      grant = '0;
      sel   = '0;
      found = 1'b0;
      for (int k = 0; k < `NOC_PORTS; k++) begin
         idx = int'(ptr) + k;
         if (idx >= `NOC_PORTS) begin
            idx = idx - `NOC_PORTS;
         end
         // first requester wins
         if (!found && req[idx]) begin
            found      = 1'b1;
            grant[idx] = 1'b1;
            sel        = IDX_W'(idx);
         end
      end
   end

   // next scan starts just after the winner
   assign ptr_next = (sel == IDX_W'(`NOC_PORTS-1)) ? '0 : sel + 1'b1;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         ptr       <= '0;
         out_valid <= 1'b0;
      end else begin
         // one flit per cycle, sink always takes it
         out_valid <= any_req;
         if (any_req) begin
            ptr <= ptr_next;
         end
      end
   end

   // payload only moves with a grant
   always_ff @(posedge clk) begin
      if (any_req) begin
         out_flit <= flits[sel];
      end
   end

endmodule

`default_nettype wire

// ==== src/flit_fifo.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module flit_fifo import noc_pkg::*; (
   input  wire   clk,
   input  wire   arst_n,
   input  wire   push,
   input  flit_t push_flit,
   input  wire   pop,
   output flit_t head,
   output logic  not_empty,
   output logic  full
);

   localparam int PTR_W = $clog2(`NOC_FIFO_DEPTH);

   flit_t             mem [`NOC_FIFO_DEPTH];
   logic [PTR_W-1:0]  rd_ptr;
   logic [PTR_W-1:0]  wr_ptr;
   // needs one bit more than the pointers to tell full from empty
   logic [PTR_W:0]    count;
   logic              do_push;
   logic              do_pop;

   // push while full is dropped
   assign do_push = push && !full;
   assign do_pop  = pop && not_empty;

   assign not_empty = (count != '0);
   assign full      = (count == (PTR_W+1)'(`NOC_FIFO_DEPTH));
   // oldest entry, seen by the route block right away
   assign head      = mem[rd_ptr];

   ////////////////////////////////////////////////////////////
   // pointers and fill level
   ////////////////////////////////////////////////////////////
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rd_ptr <= '0;
         wr_ptr <= '0;
         count  <= '0;
      end else begin
         if (do_push) begin
            wr_ptr <= (wr_ptr == PTR_W'(`NOC_FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
         end
         if (do_pop) begin
            rd_ptr <= (rd_ptr == PTR_W'(`NOC_FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
         end
         // both at once leaves the level unchanged
         if (do_push && !do_pop) begin
            count <= count + 1'b1;
         end else if (do_pop && !do_push) begin
            count <= count - 1'b1;
         end
      end
   end

   // storage
   always_ff @(posedge clk) begin
      if (do_push) begin
         mem[wr_ptr] <= push_flit;
      end
   end

endmodule

`default_nettype wire

// ==== src/route_compute_xy.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module route_compute_xy import noc_pkg::*; #(
   parameter coord_t node_x = 2'd1,
   parameter coord_t node_y = 2'd1
) (
   input  flit_t     head,
   input  wire       head_valid,
   output port_e     port,
   output port_vec_t req
);

   // one extra bit so the differences carry a sign
   logic signed [`NOC_COORD_W:0] x_cur;
   logic signed [`NOC_COORD_W:0] y_cur;
   logic signed [`NOC_COORD_W:0] x_dst;
   logic signed [`NOC_COORD_W:0] y_dst;
   logic signed [`NOC_COORD_W:0] x_diff;
   logic signed [`NOC_COORD_W:0] y_diff;

   assign x_cur = {1'b0, node_x};
   assign y_cur = {1'b0, node_y};
   // dest x above dest y in the low bits of the flit
   assign x_dst = {1'b0, head[2*`NOC_COORD_W-1:`NOC_COORD_W]};
   assign y_dst = {1'b0, head[`NOC_COORD_W-1:0]};

   assign x_diff = x_dst - x_cur;
   assign y_diff = y_dst - y_cur;

   ////////////////////////////////////////////////////////////
   // xy order: finish x first, then y, else deliver here
   ////////////////////////////////////////////////////////////
   always_comb begin
      if (!head_valid) begin
         port = port_none;
      end else if (x_diff > 0) begin
         port = port_east;
      end else if (x_diff < 0) begin
         port = port_west;
      end else if (y_diff > 0) begin
         // larger y lies to the south
         port = port_south;
      end else if (y_diff < 0) begin
         port = port_north;
      end else begin
         port = port_local;
      end
   end

   // one-hot enables from the port code
   always_comb begin
      req = '0;
      case (port)
         port_local: req[0] = 1'b1;
         port_east:  req[1] = 1'b1;
         port_west:  req[2] = 1'b1;
         port_south: req[3] = 1'b1;
         port_north: req[4] = 1'b1;
         default:    req = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== src/noc_pkg.sv ====
`default_nettype none

`include "noc_params.svh"

package noc_pkg;

   // single-flit packet
   typedef logic [`NOC_FLIT_W-1:0] flit_t;

   // node coordinate on one axis
   typedef logic [`NOC_COORD_W-1:0] coord_t;

   // bit 0 local, 1 east, 2 west, 3 south, 4 north
   typedef logic [`NOC_PORTS-1:0] port_vec_t;

   // output port codes of the route block
   typedef enum logic [3:0] {
      port_none  = 4'd0,
      port_local = 4'd1,
      port_east  = 4'd2,
      port_north = 4'd3,
      port_west  = 4'd4,
      port_south = 4'd5
   } port_e;

endpackage

`default_nettype wire

// ==== src/noc_params.svh ====
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// mesh size in nodes
`define NOC_X_NODES 4
`define NOC_Y_NODES 4

// one coordinate, enough for 4 nodes per axis
`define NOC_COORD_W 2

// tag[7:4], dest x[3:2], dest y[1:0]
`define NOC_FLIT_W 8

// local, east, west, south, north
`define NOC_PORTS 5

// entries per input fifo
`define NOC_FIFO_DEPTH 4

`endif
